// ==== rtl/inverter_defs.svh ====
// Build-time constants for the gate-drive controller
// Module count, UART and SPI timing, startup window, command codes
// Timings are scaled down for simulation

`ifndef INVERTER_DEFS_SVH
`define INVERTER_DEFS_SVH

// Power modules and sine bytes per module per round
`define NUM_MODULES     3
`define NUM_PHASES      3

// UART bit period in clocks
`define CLKS_PER_BIT    8

// SPI clock half period and idle clocks between transfers
`define SPI_HALF        2
`define SPI_GAP         4

// Startup window length in clocks
`define STARTUP_CYCLES  600

// Sine table steps between modules and between phases
`define MODULE_OFFSET   21
`define PHASE_OFFSET    7

// SPI command words
`define PIPE_CODE       16'hA5A5
`define IDLE_WORD       16'h0000

`endif

// ==== rtl/inverter_pkg.sv ====
// Shared types for the gate-drive controller
// SPI word layout, controller mode and the sine table lookup

`default_nettype none

package inverter_pkg;

    // One SPI transfer, same layout in both directions
    typedef struct packed {
        logic [7:0] id;
        logic [7:0] code;
    } spi_word_t;

    typedef enum logic [1:0] {
        MODE_STARTUP,
        MODE_PIPE,
        MODE_NORMAL
    } mode_t;

    // Quarter wave, 127 * sin(2*pi*i/64) for i = 0..16
    localparam logic [7:0] SINE_QUARTER [17] = '{
        8'd0,   8'd12,  8'd25,  8'd37,  8'd49,  8'd60,  8'd71,  8'd81,
        8'd90,  8'd98,  8'd106, 8'd112, 8'd117, 8'd122, 8'd125, 8'd126,
        8'd127
    };

    // 64-entry unipolar sine centred on 128, built from the quarter wave
    function automatic logic [7:0] sine_byte(input logic [5:0] index);
        logic [4:0] q;
        logic [7:0] amp;
        if (index[4]) begin
            q = 5'd16 - {1'b0, index[3:0]};
        end else begin
            q = {1'b0, index[3:0]};
        end
        amp = SINE_QUARTER[q];
        if (index[5]) begin
            return 8'd128 - amp;
        end
        return 8'd128 + amp;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/uart_tx.sv ====
// UART transmitter, 8 data bits LSB first, even parity, one stop bit
// busy covers the whole frame starting the cycle after start

`timescale 1ns/1ps
`default_nettype none
`include "inverter_defs.svh"

module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic [7:0] data,
    output logic       tx,
    output logic       busy
);
    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CLKS_PER_BIT - 1);

    // Remaining bits after the start bit: data, parity, stop
    logic [9:0]       frame;
    logic [3:0]       bit_cnt;
    logic [CNT_W-1:0] clk_cnt;
    logic             bit_end;

    assign bit_end = busy && (clk_cnt == CNT_LAST);

    always_ff @(posedge clk) begin
        if (reset) begin
            tx      <= 1'b1;
            busy    <= 1'b0;
            bit_cnt <= '0;
            clk_cnt <= '0;
        end else if (!busy) begin
            if (start) begin
                // Start bit goes out right away
                tx      <= 1'b0;
                busy    <= 1'b1;
                bit_cnt <= '0;
                clk_cnt <= '0;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd10) begin
                busy <= 1'b0;
            end else begin
                tx      <= frame[0];
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start) begin
            frame <= {1'b1, ^data, data};
        end else if (bit_end && bit_cnt != 4'd10) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/uart_rx.sv ====
// UART receiver, mid-bit sampling with even-parity check
// done pulses one cycle at the stop bit with data and parity flag

`timescale 1ns/1ps
`default_nettype none
`include "inverter_defs.svh"

module uart_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] data_received,
    output logic       done,
    output logic       parity_error
);
    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(`CLKS_PER_BIT / 2 - 1);

    logic [2:0]       rx_sync;
    logic             rx_s;
    logic             rx_fall;
    logic             active;
    // 0 start, 1..8 data, 9 parity, 10 stop
    logic [3:0]       bit_idx;
    logic [CNT_W-1:0] clk_cnt;
    logic [8:0]       shift;
    logic             sample;

    assign rx_s    = rx_sync[1];
    assign rx_fall = rx_sync[2] & ~rx_sync[1];
    assign sample  = active && bit_idx != 4'd0 && clk_cnt == CNT_LAST;

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_sync <= 3'b111;
        end else begin
            rx_sync <= {rx_sync[1:0], rx};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active       <= 1'b0;
            bit_idx      <= '0;
            clk_cnt      <= '0;
            done         <= 1'b0;
            parity_error <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!active) begin
                if (rx_fall) begin
                    active  <= 1'b1;
                    bit_idx <= '0;
                    clk_cnt <= '0;
                end
            end else if (bit_idx == 4'd0) begin
                // Half a bit in, the start bit must still be low
                if (clk_cnt == CNT_HALF) begin
                    clk_cnt <= '0;
                    if (rx_s) begin
                        active <= 1'b0;
                    end else begin
                        bit_idx <= 4'd1;
                    end
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end
            end else if (sample) begin
                clk_cnt <= '0;
                if (bit_idx == 4'd10) begin
                    active       <= 1'b0;
                    done         <= 1'b1;
                    parity_error <= ^shift;
                end else begin
                    bit_idx <= bit_idx + 4'd1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample && bit_idx != 4'd10) begin
            shift <= {rx_s, shift[8:1]};
        end
        if (sample && bit_idx == 4'd10) begin
            data_received <= shift[7:0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/spi_master.sv ====
// SPI master, mode 0, 16-bit words, free-running polling
// One word out and one word in per transfer, then a short idle gap

`timescale 1ns/1ps
`default_nettype none
`include "inverter_defs.svh"

module spi_master
    import inverter_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  spi_word_t tx_word,
    output spi_word_t rx_word,
    output logic      word_valid,
    output logic      sclk,
    output logic      mosi,
    output logic      cs,
    input  logic      miso
);
    localparam logic [7:0] HALF_LAST = 8'(`SPI_HALF - 1);
    localparam logic [7:0] GAP_LAST  = 8'(`SPI_GAP - 1);

    logic        active;
    logic [7:0]  div_cnt;
    // Counts sclk edges, the 32nd wraps to zero
    logic [4:0]  edge_cnt;
    logic [15:0] tx_shift;
    logic [15:0] rx_shift;
    logic        tick;

    assign tick = active && div_cnt == HALF_LAST;
    assign mosi = cs ? 1'b0 : tx_shift[15];

    always_ff @(posedge clk) begin
        if (reset) begin
            cs         <= 1'b1;
            sclk       <= 1'b0;
            active     <= 1'b0;
            div_cnt    <= '0;
            edge_cnt   <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (!active) begin
                if (div_cnt == GAP_LAST) begin
                    div_cnt  <= '0;
                    active   <= 1'b1;
                    cs       <= 1'b0;
                    edge_cnt <= '0;
                end else begin
                    div_cnt <= div_cnt + 8'd1;
                end
            end else if (tick) begin
                div_cnt  <= '0;
                sclk     <= ~sclk;
                edge_cnt <= edge_cnt + 5'd1;
                if (edge_cnt == 5'd31) begin
                    active     <= 1'b0;
                    cs         <= 1'b1;
                    word_valid <= 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 8'd1;
            end
        end
    end

    // Latch on cs fall, shift out on falling sclk, sample on rising sclk
    always_ff @(posedge clk) begin
        if (!active && div_cnt == GAP_LAST) begin
            tx_shift <= tx_word;
        end else if (tick && sclk) begin
            tx_shift <= {tx_shift[14:0], 1'b0};
        end
        if (tick && !sclk) begin
            rx_shift <= {rx_shift[14:0], miso};
        end
        if (tick && edge_cnt == 5'd31) begin
            rx_word <= rx_shift;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mode_control.sv ====
// Startup window, sticky mode register and active-low LEDs
// Pipe mode routing of SPI commands to module UARTs and reply status

`timescale 1ns/1ps
`default_nettype none
`include "inverter_defs.svh"

module mode_control
    import inverter_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  spi_word_t               rx_word,
    input  logic                    word_valid,
    output spi_word_t               tx_word,
    output mode_t                   mode,
    input  logic [`NUM_MODULES-1:0] tx_busy,
    input  logic [`NUM_MODULES-1:0] rx_done,
    input  logic [7:0]              rx_data [`NUM_MODULES],
    input  logic [`NUM_MODULES-1:0] parity_error,
    output logic [`NUM_MODULES-1:0] pipe_start,
    output logic [7:0]              pipe_data,
    output logic                    led_green,
    output logic                    led_blue
);
    localparam int ID_W  = $clog2(`NUM_MODULES);
    localparam int TMR_W = $clog2(`STARTUP_CYCLES);

    logic [TMR_W-1:0] timer;
    logic             pending;
    logic [ID_W-1:0]  cmd_target;
    logic [ID_W-1:0]  sent_target;
    spi_word_t        status;
    logic             status_armed;
    logic             cmd_ok;

    assign led_blue  = (mode != MODE_PIPE);
    assign led_green = (mode != MODE_NORMAL);
    assign tx_word   = status;

    // Real command for an existing module, nothing else in flight
    assign cmd_ok = mode == MODE_PIPE && word_valid && !pending
                    && rx_word != `IDLE_WORD && rx_word.id < 8'(`NUM_MODULES);

    always_ff @(posedge clk) begin
        if (reset) begin
            mode         <= MODE_STARTUP;
            timer        <= '0;
            pending      <= 1'b0;
            sent_target  <= '0;
            pipe_start   <= '0;
            status       <= `IDLE_WORD;
            status_armed <= 1'b0;
        end else begin
            pipe_start <= '0;
            if (mode == MODE_STARTUP) begin
                if (word_valid && rx_word == `PIPE_CODE) begin
                    mode <= MODE_PIPE;
                end else if (timer == TMR_W'(`STARTUP_CYCLES - 1)) begin
                    mode <= MODE_NORMAL;
                end
                timer <= timer + 1'b1;
            end
            if (cmd_ok) begin
                pending <= 1'b1;
            end
            if (mode == MODE_PIPE && pending && !tx_busy[cmd_target]) begin
                pipe_start[cmd_target] <= 1'b1;
                pending                <= 1'b0;
                sent_target            <= cmd_target;
            end
            // A reply has to sit through one full transfer before it clears
            if (mode == MODE_PIPE && rx_done[sent_target]) begin
                status.id    <= {parity_error[sent_target], 7'(sent_target)};
                status.code  <= rx_data[sent_target];
                status_armed <= 1'b0;
            end else if (word_valid && status != `IDLE_WORD) begin
                if (status_armed) begin
                    status       <= `IDLE_WORD;
                    status_armed <= 1'b0;
                end else begin
                    status_armed <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_ok) begin
            cmd_target <= rx_word.id[ID_W-1:0];
            pipe_data  <= rx_word.code;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/phase_sequencer.sv ====
// Normal mode sine streaming to every module in parallel
// One frame per phase, then a one-cycle shoot pulse per round

`timescale 1ns/1ps
`default_nettype none
`include "inverter_defs.svh"

module phase_sequencer
    import inverter_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enable,
    input  logic [`NUM_MODULES-1:0] tx_busy,
    output logic [`NUM_MODULES-1:0] seq_start,
    output logic [7:0]              seq_data [`NUM_MODULES],
    output logic                    shoot
);
    localparam int PH_W = $clog2(`NUM_PHASES);
    localparam logic [PH_W-1:0] PH_LAST = PH_W'(`NUM_PHASES - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SEND,
        S_WAIT,
        S_SHOOT
    } seq_state_t;

    seq_state_t      state;
    logic [5:0]      step;
    logic [PH_W-1:0] phase;

    assign seq_start = {`NUM_MODULES{state == S_SEND}};
    assign shoot     = (state == S_SHOOT);

    // Table index wraps at 64
    always_comb begin
        for (int m = 0; m < `NUM_MODULES; m++) begin
            seq_data[m] = sine_byte(6'(int'(step) + m * `MODULE_OFFSET
                                       + int'(phase) * `PHASE_OFFSET));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            step  <= '0;
            phase <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (enable) begin
                        state <= S_SEND;
                    end
                end
                // UART busy rises on the next edge
                S_SEND: state <= S_WAIT;
                S_WAIT: begin
                    if (tx_busy == '0) begin
                        if (phase == PH_LAST) begin
                            phase <= '0;
                            state <= S_SHOOT;
                        end else begin
                            phase <= phase + 1'b1;
                            state <= S_SEND;
                        end
                    end
                end
                S_SHOOT: begin
                    step  <= step + 6'd1;
                    state <= S_SEND;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/inverter_top.sv ====
// Gate-drive controller top level
// SPI master, mode controller, sine sequencer, one UART pair per module

`timescale 1ns/1ps
`default_nettype none
`include "inverter_defs.svh"

module inverter_top
    import inverter_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`NUM_MODULES-1:0] uart_rx_lines,
    output logic [`NUM_MODULES-1:0] uart_tx_lines,
    output logic                    sclk,
    output logic                    mosi,
    output logic                    cs,
    input  logic                    miso,
    output logic                    led_green,
    output logic                    led_blue,
    output logic                    shoot
);
    spi_word_t               spi_rx;
    spi_word_t               spi_tx;
    logic                    word_valid;
    mode_t                   mode;
    logic                    normal_mode;
    logic [`NUM_MODULES-1:0] tx_busy;
    logic [`NUM_MODULES-1:0] rx_done;
    logic [`NUM_MODULES-1:0] parity_error;
    logic [`NUM_MODULES-1:0] pipe_start;
    logic [`NUM_MODULES-1:0] seq_start;
    logic [7:0]              pipe_data;
    logic [7:0]              rx_data  [`NUM_MODULES];
    logic [7:0]              seq_data [`NUM_MODULES];

    assign normal_mode = (mode == MODE_NORMAL);

    spi_master u_spi (
        .clk(clk), .reset(reset),
        .tx_word(spi_tx), .rx_word(spi_rx), .word_valid(word_valid),
        .sclk(sclk), .mosi(mosi), .cs(cs), .miso(miso)
    );

    mode_control u_ctrl (
        .clk(clk), .reset(reset),
        .rx_word(spi_rx), .word_valid(word_valid), .tx_word(spi_tx), .mode(mode),
        .tx_busy(tx_busy), .rx_done(rx_done), .rx_data(rx_data),
        .parity_error(parity_error), .pipe_start(pipe_start), .pipe_data(pipe_data),
        .led_green(led_green), .led_blue(led_blue)
    );

    phase_sequencer u_seq (
        .clk(clk), .reset(reset), .enable(normal_mode), .tx_busy(tx_busy),
        .seq_start(seq_start), .seq_data(seq_data), .shoot(shoot)
    );

    for (genvar m = 0; m < `NUM_MODULES; m++) begin : g_module
        logic       start;
        logic [7:0] data;

        // Sequencer owns the transmitters in normal mode
        assign start = normal_mode ? seq_start[m] : pipe_start[m];
        assign data  = normal_mode ? seq_data[m]  : pipe_data;

        uart_tx u_tx (
            .clk(clk), .reset(reset), .start(start), .data(data),
            .tx(uart_tx_lines[m]), .busy(tx_busy[m])
        );

        uart_rx u_rx (
            .clk(clk), .reset(reset), .rx(uart_rx_lines[m]),
            .data_received(rx_data[m]), .done(rx_done[m]),
            .parity_error(parity_error[m])
        );
    end

endmodule

`default_nettype wire

// ==== test/inverter_assert.sv ====
// Protocol assertions for the gate-drive controller top level
// Shoot width and mode, chip select in reset, sticky LEDs

`timescale 1ns/1ps
`default_nettype none

module inverter_assert
    import inverter_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  shoot,
    input logic  cs,
    input logic  led_green,
    input logic  led_blue,
    input mode_t mode
);
    // Shoot is a single-cycle strobe
    shoot_one_cycle: assert property (@(posedge clk) disable iff (reset)
        shoot |=> !shoot)
        else $error("shoot stayed high for more than one cycle");

    shoot_only_normal: assert property (@(posedge clk) disable iff (reset)
        $rose(shoot) |-> mode == MODE_NORMAL)
        else $error("shoot rose outside normal mode");

    cs_high_in_reset: assert property (@(posedge clk)
        reset |=> cs)
        else $error("cs was low during reset");

    // Mode is sticky, so a lit LED stays lit until reset
    leds_sticky: assert property (@(posedge clk) disable iff (reset)
        (!led_green || !led_blue) |=> $stable({led_green, led_blue}))
        else $error("an LED changed after a mode was entered");

endmodule

`default_nettype wire

// ==== test/inverter_tb.sv ====
// Testbench for the gate-drive controller
// SPI slave and UART module models, startup, normal stream and pipe tests
// Cycle-limit timeout and a closing summary

`timescale 1ns/1ps
`default_nettype none
`include "inverter_defs.svh"

module inverter_tb
    import inverter_pkg::*;
;
    localparam int NM           = `NUM_MODULES;
    localparam int BIT_NS       = `CLKS_PER_BIT * 40;
    localparam int FRAME_CYCLES = 11 * `CLKS_PER_BIT;
    localparam int XFER_CYCLES  = 32 * `SPI_HALF + `SPI_GAP;
    // Startup window, two normal rounds and one command and reply per module, with slack
    localparam int TEST_CYCLES  = `STARTUP_CYCLES + 4 * `NUM_PHASES * FRAME_CYCLES
                                  + 2 * NM * (4 * XFER_CYCLES + 3 * FRAME_CYCLES);
    localparam int CYCLE_LIMIT  = 4 * TEST_CYCLES;

    logic          clk;
    logic          reset;
    logic [NM-1:0] rx_lines;
    logic [NM-1:0] tx_lines;
    logic          sclk;
    logic          mosi;
    logic          cs;
    logic          miso;
    logic          led_green;
    logic          led_blue;
    logic          shoot;

    // SPI slave model state
    spi_word_t   default_word;
    spi_word_t   cmd_q [$];
    spi_word_t   mosi_q [$];
    logic [15:0] miso_word;
    logic [15:0] mosi_shift;
    int          spi_bit;
    logic        prev_sclk;
    logic        prev_cs;

    // Decoded frames per module with the received parity in bit 8
    logic [8:0]  frames [NM][$];
    int          shoot_frames [$];
    logic [31:0] rng_state;
    string       cur_test;
    int          errors;
    int          checks;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          cycles;

    inverter_top DUT (
        .clk(clk), .reset(reset), .uart_rx_lines(rx_lines), .uart_tx_lines(tx_lines),
        .sclk(sclk), .mosi(mosi), .cs(cs), .miso(miso),
        .led_green(led_green), .led_blue(led_blue), .shoot(shoot)
    );

    bind inverter_top inverter_assert u_assert (
        .clk(clk), .reset(reset), .shoot(shoot), .cs(cs),
        .led_green(led_green), .led_blue(led_blue), .mode(mode)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    // Slave shifts miso after falling sclk, captures mosi after rising sclk
    always @(negedge clk) begin
        if (prev_cs && !cs) begin
            if (cmd_q.size() > 0) begin
                miso_word = cmd_q.pop_front();
            end else begin
                miso_word = default_word;
            end
            spi_bit = 0;
            miso = miso_word[15];
        end else if (!cs && prev_sclk && !sclk) begin
            spi_bit++;
            if (spi_bit < 16) begin
                miso = miso_word[4'(15 - spi_bit)];
            end
        end
        if (!cs && !prev_sclk && sclk) begin
            mosi_shift = {mosi_shift[14:0], mosi};
        end
        if (!prev_cs && cs && !reset) begin
            mosi_q.push_back(mosi_shift);
        end
        prev_sclk = sclk;
        prev_cs = cs;
    end

    always @(negedge clk) begin
        if (shoot) begin
            shoot_frames.push_back(frames[0].size());
        end
    end

    // Mid-bit sampling of each module's tx line
    for (genvar m = 0; m < NM; m++) begin : g_mon
        logic [8:0] bits;

        always begin
            @(negedge tx_lines[m]);
            #(BIT_NS / 2 - 10);
            if (tx_lines[m] == 1'b0) begin
                for (int i = 0; i < 9; i++) begin
                    #(BIT_NS);
                    bits[i] = tx_lines[m];
                end
                #(BIT_NS);
                if (tx_lines[m] !== 1'b1) begin
                    $display("Module %0d sent a frame without a stop bit", m);
                    errors++;
                end
                frames[m].push_back(bits);
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Never zero, so a command or reply cannot look like the idle word
    function automatic logic [7:0] random_byte();
        rng_state = xorshift32(rng_state);
        if (rng_state[7:0] == 8'h00) begin
            return 8'h5A;
        end
        return rng_state[7:0];
    endfunction

    // Unipolar sine around 128 with amplitude 127
    function automatic logic [7:0] expected_sine(input int idx);
        real a;
        int  amp;
        int  i;
        i = idx % 64;
        a = 127.0 * $sin(2.0 * 3.14159265358979 * i / 64.0);
        if (a < 0.0) begin
            a = -a;
        end
        amp = $rtoi(a + 0.5);
        if (i < 32) begin
            return 8'(128 + amp);
        end
        return 8'(128 - amp);
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: FAIL", cur_test);
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        rx_lines = '1;
        cmd_q.delete();
        repeat (10) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic clear_frames();
        for (int m = 0; m < NM; m++) begin
            frames[m].delete();
        end
        shoot_frames.delete();
        mosi_q.delete();
    endtask

    // Frame with start, data LSB first, parity, stop
    task automatic send_reply(input int m, input logic [7:0] b, input logic bad);
        logic [10:0] f;
        f = {1'b1, ^b ^ bad, b, 1'b0};
        for (int i = 0; i < 11; i++) begin
            rx_lines[m] = f[i];
            repeat (`CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    task automatic forward_command(input int m);
        logic [7:0] code;
        logic [8:0] f;
        int         n;
        code = random_byte();
        n = frames[m].size();
        cmd_q.push_back({8'(m), code});
        while (frames[m].size() == n) @(negedge clk);
        f = frames[m][n];
        check_value($sformatf("module %0d byte", m), int'(code), int'(f[7:0]));
        check_value($sformatf("module %0d parity", m), int'(^code), int'(f[8]));
    endtask

    initial begin
        int         cnt;
        int         idx;
        logic [8:0] f;
        logic [7:0] b;
        logic       bad;
        logic       found;
        spi_word_t  w;
        reset = 1'b1;
        rx_lines = '1;
        miso = 1'b0;
        prev_sclk = 1'b0;
        prev_cs = 1'b1;
        mosi_shift = '0;
        spi_bit = 0;
        default_word = `IDLE_WORD;
        rng_state = 32'd6;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        cycles = 0;

        begin_test("reset_state");
        apply_reset();
        check_value("cs", 1, int'(cs));
        check_value("tx lines", (1 << NM) - 1, int'(tx_lines));
        check_value("green", 1, int'(led_green));
        check_value("blue", 1, int'(led_blue));
        check_value("shoot", 0, int'(shoot));
        end_test();

        begin_test("normal_entry");
        cnt = 0;
        while (led_green) begin
            @(negedge clk);
            cnt++;
        end
        check_value("startup cycles", `STARTUP_CYCLES, cnt);
        check_value("blue", 1, int'(led_blue));
        end_test();

        begin_test("normal_stream");
        while (shoot_frames.size() < 2) @(negedge clk);
        check_value("frames at shoot 1", `NUM_PHASES, shoot_frames[0]);
        check_value("frames at shoot 2", 2 * `NUM_PHASES, shoot_frames[1]);
        for (int m = 0; m < NM; m++) begin
            check_value($sformatf("module %0d frame count", m), 1,
                        int'(frames[m].size() >= 2 * `NUM_PHASES));
            for (int s = 0; s < 2 && frames[m].size() >= 2 * `NUM_PHASES; s++) begin
                for (int p = 0; p < `NUM_PHASES; p++) begin
                    f = frames[m][s * `NUM_PHASES + p];
                    idx = s + m * `MODULE_OFFSET + p * `PHASE_OFFSET;
                    b = expected_sine(idx);
                    check_value($sformatf("m%0d s%0d p%0d", m, s, p), int'(b), int'(f[7:0]));
                    check_value($sformatf("m%0d s%0d p%0d parity", m, s, p),
                                int'(^b), int'(f[8]));
                end
            end
        end
        end_test();

        begin_test("pipe_forward");
        default_word = `PIPE_CODE;
        apply_reset();
        while (led_blue) @(negedge clk);
        check_value("green", 1, int'(led_green));
        default_word = `IDLE_WORD;
        // Let a frame cut short by reset run out
        repeat (12 * `CLKS_PER_BIT) @(negedge clk);
        clear_frames();
        for (int m = 0; m < NM; m++) begin
            forward_command(m);
        end
        end_test();

        begin_test("pipe_reply");
        for (int m = 0; m < NM; m++) begin
            forward_command(m);
            b = random_byte();
            bad = (m == NM - 1);
            mosi_q.delete();
            send_reply(m, b, bad);
            found = 1'b0;
            while (!found) begin
                @(negedge clk);
                while (mosi_q.size() > 0 && !found) begin
                    w = mosi_q.pop_front();
                    found = (w != `IDLE_WORD);
                end
            end
            check_value($sformatf("module %0d reply id", m), int'({bad, 7'(m)}), int'(w.id));
            check_value($sformatf("module %0d reply code", m), int'(b), int'(w.code));
        end
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+rtl
rtl/inverter_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/spi_master.sv
rtl/mode_control.sv
rtl/phase_sequencer.sv
rtl/inverter_top.sv
test/inverter_assert.sv
test/inverter_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := inverter_tb
FILELIST  := src.f
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
